// File: bench/gat_clock_gen.sv
`timescale 1ns/1ps

module gat_clock_gen (
  output logic clk_o
);

  // Half of the 100 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

endmodule

// File: bench/gat_layer_tb.sv
`timescale 1ns/1ps

module gat_layer_tb
  import gat_pkg::*;
();

  // Word offsets inside the vector file
  localparam int VEC_DEPTH      = 256;
  localparam int COL_IDX_BASE   = 'h00;
  localparam int VALUE_BASE     = 'h40;
  localparam int NODE_INFO_BASE = 'h80;
  localparam int WEIGHT_BASE    = 'h90;
  localparam int A_BASE         = 'hB0;
  localparam int GROUPS_BASE    = 'hB8;
  localparam int EXPECT_BASE    = 'hC0;
  localparam int EXPECT_WORDS   = MAX_NODES + 1;
  localparam int LOAD_DELAY_MAX = 16;
  localparam int HOLD_CYCLES    = 20;
  localparam int TAIL_CYCLES    = 10;

  logic                        clk;
  logic                        rst_n;
  logic [COL_IDX_ADDR_W-1:0]   col_idx_addr_o;
  logic [COL_W-1:0]            col_idx_dout_i;
  logic [COL_IDX_ADDR_W-1:0]   value_addr_o;
  logic [DATA_W-1:0]           value_dout_i;
  logic [NODE_INFO_ADDR_W-1:0] node_info_addr_o;
  node_info_t                  node_info_dout_i;
  logic                        h_load_done_i;
  logic [WEIGHT_ADDR_W-1:0]    weight_addr_o;
  logic [DATA_W-1:0]           weight_dout_i;
  logic                        weight_load_done_i;
  logic [A_ADDR_W-1:0]         a_addr_o;
  logic [DATA_W-1:0]           a_dout_i;
  logic                        a_load_done_i;
  logic [GROUP_W-1:0]          num_groups_i;
  logic                        out_ready_i;
  logic                        out_valid_o;
  coef_t                       out_coef_o;
  logic                        done_o;

  logic [15:0]       vec_mem       [VEC_DEPTH];
  logic [COL_W-1:0]  col_idx_mem   [COL_IDX_DEPTH];
  logic [DATA_W-1:0] value_mem     [COL_IDX_DEPTH];
  node_info_t        node_info_mem [NODE_INFO_DEPTH];
  logic [DATA_W-1:0] weight_mem    [WEIGHT_DEPTH];
  logic [DATA_W-1:0] a_mem         [A_DEPTH];
  coef_t             expected_q    [MAX_GROUPS];
  int                num_groups;
  int                drained;
  int                produced;
  int                seed;
  logic              ready_random;
  logic              ready_high;
  logic              done_seen;

  gat_clock_gen u_clock_gen (
    .clk_o (clk)
  );

  gat_layer_top UUT (
    .clk                (clk),
    .rst_n              (rst_n),
    .col_idx_addr_o     (col_idx_addr_o),
    .col_idx_dout_i     (col_idx_dout_i),
    .value_addr_o       (value_addr_o),
    .value_dout_i       (value_dout_i),
    .node_info_addr_o   (node_info_addr_o),
    .node_info_dout_i   (node_info_dout_i),
    .h_load_done_i      (h_load_done_i),
    .weight_addr_o      (weight_addr_o),
    .weight_dout_i      (weight_dout_i),
    .weight_load_done_i (weight_load_done_i),
    .a_addr_o           (a_addr_o),
    .a_dout_i           (a_dout_i),
    .a_load_done_i      (a_load_done_i),
    .num_groups_i       (num_groups_i),
    .out_ready_i        (out_ready_i),
    .out_valid_o        (out_valid_o),
    .out_coef_o         (out_coef_o),
    .done_o             (done_o)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_run(input string what);
    $display("error: %s", what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic load_vectors();
    for (int i = 0; i < VEC_DEPTH; i++) begin
      vec_mem[i] = '0;
    end
    $readmemh("bench/gat_layer_vectors.txt", vec_mem);
    for (int i = 0; i < COL_IDX_DEPTH; i++) begin
      col_idx_mem[i] = vec_mem[COL_IDX_BASE + i][COL_W-1:0];
      value_mem[i]   = vec_mem[VALUE_BASE + i][DATA_W-1:0];
    end
    for (int i = 0; i < NODE_INFO_DEPTH; i++) begin
      node_info_mem[i] = vec_mem[NODE_INFO_BASE + i][$bits(node_info_t)-1:0];
    end
    for (int i = 0; i < WEIGHT_DEPTH; i++) begin
      weight_mem[i] = vec_mem[WEIGHT_BASE + i][DATA_W-1:0];
    end
    for (int i = 0; i < A_DEPTH; i++) begin
      a_mem[i] = vec_mem[A_BASE + i][DATA_W-1:0];
    end
    num_groups = vec_mem[GROUPS_BASE];
    if (num_groups < 1 || num_groups > MAX_GROUPS) begin
      fail_run("group count in the vector file is out of range");
    end
    for (int g = 0; g < MAX_GROUPS; g++) begin
      expected_q[g].num_nodes = vec_mem[EXPECT_BASE + g * EXPECT_WORDS][NUM_NODES_W-1:0];
      for (int j = 0; j < MAX_NODES; j++) begin
        expected_q[g].coef[j] = vec_mem[EXPECT_BASE + g * EXPECT_WORDS + 1 + j][COEF_W-1:0];
      end
    end
  endtask

  // External memories with one cycle read latency
  always @(posedge clk) begin
    col_idx_dout_i   <= col_idx_mem[col_idx_addr_o];
    value_dout_i     <= value_mem[value_addr_o];
    node_info_dout_i <= node_info_mem[node_info_addr_o];
    weight_dout_i    <= weight_mem[weight_addr_o];
    a_dout_i         <= a_mem[a_addr_o];
  end

  always @(posedge clk) begin
    if (ready_high) begin
      out_ready_i <= 1'b1;
    end else if (ready_random) begin
      out_ready_i <= ($random(seed) % 2) != 0;
    end else begin
      out_ready_i <= 1'b0;
    end
  end

  // Pop happens at the next rising edge
  always @(negedge clk) begin
    if (rst_n && out_valid_o && out_ready_i) begin
      if (drained >= num_groups) begin
        fail_run("a group came out after all expected groups were drained");
      end
      check_value($sformatf("group %0d num_nodes", drained),
                  expected_q[drained].num_nodes, out_coef_o.num_nodes);
      for (int j = 0; j < MAX_NODES; j++) begin
        check_value($sformatf("group %0d slot %0d", drained, j),
                    expected_q[drained].coef[j], out_coef_o.coef[j]);
      end
      drained = drained + 1;
    end
  end

  always @(negedge clk) begin
    if (rst_n && !(h_load_done_i && weight_load_done_i && a_load_done_i)) begin
      check_value("before loads out_valid_o", 0, out_valid_o);
      check_value("before loads done_o", 0, done_o);
    end
    if (rst_n && UUT.coef_valid) begin
      produced = produced + 1;
    end
    if (rst_n && done_o && produced < num_groups) begin
      fail_run("done_o rose before every group was produced");
    end
    if (done_seen && !done_o) begin
      fail_run("done_o fell after it had been raised");
    end
    if (rst_n && done_o) begin
      done_seen = 1'b1;
    end
  end

  initial begin : watchdog
    int limit;
    @(posedge clk);
    limit = 200 * num_groups + WEIGHT_DEPTH + A_DEPTH + 5 + LOAD_DELAY_MAX +
            HOLD_CYCLES + TAIL_CYCLES;
    repeat (limit) @(posedge clk);
    fail_run($sformatf("run did not finish within %0d cycles", limit));
  end

  initial begin : main_flow
    int h_delay;
    int w_delay;
    int a_delay;
    seed               = 32'h143fa32e;
    rst_n              = 1'b0;
    h_load_done_i      = 1'b0;
    weight_load_done_i = 1'b0;
    a_load_done_i      = 1'b0;
    num_groups_i       = '0;
    out_ready_i        = 1'b0;
    col_idx_dout_i     = '0;
    value_dout_i       = '0;
    node_info_dout_i   = '0;
    weight_dout_i      = '0;
    a_dout_i           = '0;
    ready_random       = 1'b0;
    ready_high         = 1'b0;
    done_seen          = 1'b0;
    drained            = 0;
    produced           = 0;
    load_vectors();
    h_delay = 1 + ($unsigned($random(seed)) % LOAD_DELAY_MAX);
    w_delay = 1 + ($unsigned($random(seed)) % LOAD_DELAY_MAX);
    a_delay = 1 + ($unsigned($random(seed)) % LOAD_DELAY_MAX);

    repeat (5) @(posedge clk);
    rst_n        <= 1'b1;
    num_groups_i <= GROUP_W'(num_groups);

    // Memories report loaded at staggered times
    for (int cyc = 1; cyc <= LOAD_DELAY_MAX; cyc++) begin
      @(posedge clk);
      if (cyc == h_delay) begin
        h_load_done_i <= 1'b1;
      end
      if (cyc == w_delay) begin
        weight_load_done_i <= 1'b1;
      end
      if (cyc == a_delay) begin
        a_load_done_i <= 1'b1;
      end
    end

    // Hold back-pressure until the ring is full and a while longer
    if (num_groups >= RING_DEPTH) begin
      wait (UUT.ring_full === 1'b1);
      repeat (HOLD_CYCLES) begin
        @(negedge clk);
        check_value("hold ring_full", 1, UUT.ring_full);
        check_value("hold out_valid_o", 1, out_valid_o);
        check_value("hold oldest slot 0", expected_q[0].coef[0], out_coef_o.coef[0]);
      end
    end

    ready_random = 1'b1;
    wait (drained == num_groups);
    wait (done_o === 1'b1);

    ready_random = 1'b0;
    ready_high   = 1'b1;
    repeat (TAIL_CYCLES) begin
      @(negedge clk);
      check_value("after done out_valid_o", 0, out_valid_o);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: bench/gat_layer_vectors.txt
// Hex words by section: col_idx @000, value @040, node_info {row_len,num_nodes,flag} @080,
// weight row-major @090, a @0B0, group count @0B8, expected groups @0C0 as num_nodes c0 c1 c2 c3
@000
0 2 1 3 4 5 7 0 6 2 4 1 7 0 3 5
6 2 4 1 3
@040
01 02 03 01 02 01 01 02 05 03 04 01 02 01 01 02
01 01 03 07 02
@080
25 10 27 00 30 13 15 20 19 20 10 30 23
@090
01 02 03 04
02 01 00 03
00 01 02 01
03 00 01 02
01 01 01 01
02 03 01 00
00 02 00 02
04 01 02 03
@0B0
01 02 01 03 02 01 03 01
@0B8
6
@0C0
2 0043 003A 0000 0000
3 0031 0018 0056 0000
1 0046 0000 0000 0000
2 002D 0039 0000 0000
4 0046 003E 0036 0043
1 00BD 0000 0000 0000

// File: gat_layer.f
source/gat_pkg.sv
source/weight_loader.sv
source/a_loader.sv
source/spmm.sv
source/dmvm.sv
source/coef_ring.sv
source/gat_scheduler.sv
source/gat_layer_top.sv
bench/gat_clock_gen.sv
bench/gat_layer_tb.sv

// File: source/a_loader.sv
`timescale 1ns/1ps

module a_loader
  import gat_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           load_done_i,
  input  logic [DATA_W-1:0]              a_dout_i,
  output logic [A_ADDR_W-1:0]            a_addr_o,
  output logic                           a_ready_o,
  output logic [A_DEPTH-1:0][DATA_W-1:0] a_o
);

  logic                load_done_q;
  logic                busy_q;
  logic                rd_valid_q;
  logic [A_ADDR_W-1:0] rd_idx_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_done_q <= 1'b0;
      busy_q      <= 1'b0;
      rd_valid_q  <= 1'b0;
      a_addr_o    <= '0;
      a_ready_o   <= 1'b0;
    end else begin
      load_done_q <= load_done_i;
      if (load_done_i && !load_done_q) begin
        busy_q <= 1'b1;
      end else if (busy_q && a_addr_o == A_ADDR_W'(A_DEPTH - 1)) begin
        busy_q <= 1'b0;
      end
      if (busy_q) begin
        a_addr_o <= a_addr_o + 1'b1;
      end
      rd_valid_q <= busy_q;
      if (rd_valid_q && rd_idx_q == A_ADDR_W'(A_DEPTH - 1)) begin
        a_ready_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_idx_q <= a_addr_o;
    if (rd_valid_q) begin
      a_o[rd_idx_q] <= a_dout_i;
    end
  end

endmodule

// File: source/coef_ring.sv
`timescale 1ns/1ps

module coef_ring
  import gat_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr_i,
  input  coef_t wr_data_i,
  input  logic  out_ready_i,
  output logic  full_o,
  output logic  out_valid_o,
  output coef_t out_coef_o
);

  coef_t                 mem_q [RING_DEPTH];
  logic [RING_PTR_W-1:0] wr_ptr_q;
  logic [RING_PTR_W-1:0] rd_ptr_q;
  logic [RING_CNT_W-1:0] count_q;
  logic                  do_wr;
  logic                  do_rd;

  assign full_o      = (count_q == RING_CNT_W'(RING_DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_coef_o  = mem_q[rd_ptr_q];

  // Pop on handshake, a write at full only goes in alongside a pop
  assign do_rd = out_valid_o && out_ready_i;
  assign do_wr = wr_i && (!full_o || do_rd);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

endmodule

// File: source/dmvm.sv
`timescale 1ns/1ps

module dmvm
  import gat_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wh_valid_i,
  input  wh_row_t                        wh_row_i,
  input  logic [A_DEPTH-1:0][DATA_W-1:0] a_i,
  output logic                           coef_valid_o,
  output coef_t                          coef_o
);

  logic [COEF_W-1:0]      s_self_now;
  logic [COEF_W-1:0]      s_nb_now;
  logic [COEF_W-1:0]      s_self_q;
  logic [NUM_NODES_W-1:0] member_q;
  logic [NUM_NODES_W-1:0] member_now;
  logic                   last_member;

  // Both halves of a against the incoming row
  always_comb begin
    s_self_now = '0;
    s_nb_now   = '0;
    for (int k = 0; k < W_COLS; k++) begin
      s_self_now = s_self_now + a_i[k] * wh_row_i.wh[k];
      s_nb_now   = s_nb_now + a_i[W_COLS + k] * wh_row_i.wh[k];
    end
  end

  // Target row restarts the member count
  assign member_now  = wh_row_i.flag ? '0 : member_q;
  assign last_member = (member_now + 1'b1) == wh_row_i.num_nodes;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      coef_valid_o <= 1'b0;
      member_q     <= '0;
    end else begin
      coef_valid_o <= wh_valid_i && last_member;
      if (wh_valid_i) begin
        member_q <= member_now + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wh_valid_i) begin
      if (wh_row_i.flag) begin
        s_self_q         <= s_self_now;
        coef_o.num_nodes <= wh_row_i.num_nodes;
        for (int j = 0; j < MAX_NODES; j++) begin
          if (j == 0) begin
            coef_o.coef[j] <= s_self_now + s_nb_now;
          end else begin
            coef_o.coef[j] <= '0;
          end
        end
      end else begin
        coef_o.coef[member_now] <= s_self_q + s_nb_now;
      end
    end
  end

endmodule

// File: source/gat_layer_top.sv
`timescale 1ns/1ps

module gat_layer_top
  import gat_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  // H memories
  output logic [COL_IDX_ADDR_W-1:0]   col_idx_addr_o,
  input  logic [COL_W-1:0]            col_idx_dout_i,
  output logic [COL_IDX_ADDR_W-1:0]   value_addr_o,
  input  logic [DATA_W-1:0]           value_dout_i,
  output logic [NODE_INFO_ADDR_W-1:0] node_info_addr_o,
  input  node_info_t                  node_info_dout_i,
  input  logic                        h_load_done_i,
  // W memory
  output logic [WEIGHT_ADDR_W-1:0]    weight_addr_o,
  input  logic [DATA_W-1:0]           weight_dout_i,
  input  logic                        weight_load_done_i,
  // Attention vector memory
  output logic [A_ADDR_W-1:0]         a_addr_o,
  input  logic [DATA_W-1:0]           a_dout_i,
  input  logic                        a_load_done_i,
  input  logic [GROUP_W-1:0]          num_groups_i,
  // Drain side
  input  logic                        out_ready_i,
  output logic                        out_valid_o,
  output coef_t                       out_coef_o,
  output logic                        done_o
);

  logic                                      w_ready;
  logic                                      a_ready;
  logic [W_ROWS-1:0][W_COLS-1:0][DATA_W-1:0] w_mat;
  logic [A_DEPTH-1:0][DATA_W-1:0]            a_vec;
  logic                                      group_start;
  logic                                      wh_valid;
  wh_row_t                                   wh_row;
  logic                                      coef_valid;
  coef_t                                     coef;
  logic                                      ring_full;

  gat_scheduler u_scheduler (
    .clk           (clk),
    .rst_n         (rst_n),
    .h_load_done_i (h_load_done_i),
    .w_ready_i     (w_ready),
    .a_ready_i     (a_ready),
    .num_groups_i  (num_groups_i),
    .ring_full_i   (ring_full),
    .coef_valid_i  (coef_valid),
    .group_start_o (group_start),
    .done_o        (done_o)
  );

  weight_loader u_weight_loader (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_done_i   (weight_load_done_i),
    .weight_dout_i (weight_dout_i),
    .weight_addr_o (weight_addr_o),
    .w_ready_o     (w_ready),
    .w_o           (w_mat)
  );

  a_loader u_a_loader (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_done_i (a_load_done_i),
    .a_dout_i    (a_dout_i),
    .a_addr_o    (a_addr_o),
    .a_ready_o   (a_ready),
    .a_o         (a_vec)
  );

  spmm u_spmm (
    .clk              (clk),
    .rst_n            (rst_n),
    .group_start_i    (group_start),
    .w_i              (w_mat),
    .node_info_dout_i (node_info_dout_i),
    .col_idx_dout_i   (col_idx_dout_i),
    .value_dout_i     (value_dout_i),
    .node_info_addr_o (node_info_addr_o),
    .col_idx_addr_o   (col_idx_addr_o),
    .value_addr_o     (value_addr_o),
    .wh_valid_o       (wh_valid),
    .wh_row_o         (wh_row)
  );

  dmvm u_dmvm (
    .clk          (clk),
    .rst_n        (rst_n),
    .wh_valid_i   (wh_valid),
    .wh_row_i     (wh_row),
    .a_i          (a_vec),
    .coef_valid_o (coef_valid),
    .coef_o       (coef)
  );

  coef_ring u_coef_ring (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_i        (coef_valid),
    .wr_data_i   (coef),
    .out_ready_i (out_ready_i),
    .full_o      (ring_full),
    .out_valid_o (out_valid_o),
    .out_coef_o  (out_coef_o)
  );

endmodule

// File: source/gat_pkg.sv
package gat_pkg;

  // Datapath sizes
  localparam int DATA_W     = 8;
  localparam int W_ROWS     = 8;
  localparam int W_COLS     = 4;
  localparam int MAX_NODES  = 4;
  localparam int WH_W       = 16;
  localparam int COEF_W     = 16;
  localparam int RING_DEPTH = 4;

  // External memory depths
  localparam int COL_IDX_DEPTH   = 64;
  localparam int NODE_INFO_DEPTH = 16;
  localparam int WEIGHT_DEPTH    = W_ROWS * W_COLS;
  localparam int A_DEPTH         = 2 * W_COLS;
  localparam int MAX_GROUPS      = 8;

  localparam int COL_IDX_ADDR_W   = $clog2(COL_IDX_DEPTH);
  localparam int NODE_INFO_ADDR_W = $clog2(NODE_INFO_DEPTH);
  localparam int WEIGHT_ADDR_W    = $clog2(WEIGHT_DEPTH);
  localparam int A_ADDR_W         = $clog2(A_DEPTH);
  localparam int GROUP_W          = $clog2(MAX_GROUPS + 1);

  // Field and pointer widths
  localparam int COL_W       = $clog2(W_ROWS);
  localparam int W_COL_W     = $clog2(W_COLS);
  localparam int ROW_LEN_W   = 4;
  localparam int NUM_NODES_W = 3;
  localparam int RING_PTR_W  = $clog2(RING_DEPTH);
  localparam int RING_CNT_W  = $clog2(RING_DEPTH + 1);

  // One word of the node-info memory
  typedef struct packed {
    logic [ROW_LEN_W-1:0]   row_len;
    logic [NUM_NODES_W-1:0] num_nodes;
    logic                   flag;
  } node_info_t;

  typedef struct packed {
    logic [W_COLS-1:0][WH_W-1:0] wh;
    logic                        flag;
    logic [NUM_NODES_W-1:0]      num_nodes;
  } wh_row_t;

  // Coefficients of one neighborhood, slot 0 is the target
  typedef struct packed {
    logic [MAX_NODES-1:0][COEF_W-1:0] coef;
    logic [NUM_NODES_W-1:0]           num_nodes;
  } coef_t;

endpackage

// File: source/gat_scheduler.sv
`timescale 1ns/1ps

module gat_scheduler
  import gat_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               h_load_done_i,
  input  logic               w_ready_i,
  input  logic               a_ready_i,
  input  logic [GROUP_W-1:0] num_groups_i,
  input  logic               ring_full_i,
  input  logic               coef_valid_i,
  output logic               group_start_o,
  output logic               done_o
);

  logic               loads_ready;
  logic               issue;
  logic               in_flight_q;
  logic [GROUP_W-1:0] issued_q;
  logic [GROUP_W-1:0] completed_q;

  assign loads_ready = h_load_done_i && w_ready_i && a_ready_i;

  // One group at a time, and only with room left in the ring
  assign issue = loads_ready && !in_flight_q && !ring_full_i &&
                 (issued_q < num_groups_i);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      group_start_o <= 1'b0;
      in_flight_q   <= 1'b0;
      issued_q      <= '0;
      completed_q   <= '0;
      done_o        <= 1'b0;
    end else begin
      group_start_o <= issue;
      if (issue) begin
        in_flight_q <= 1'b1;
        issued_q    <= issued_q + 1'b1;
      end else if (coef_valid_i) begin
        in_flight_q <= 1'b0;
      end
      if (coef_valid_i) begin
        completed_q <= completed_q + 1'b1;
      end
      // Sticky once every group has completed
      if (loads_ready && completed_q == num_groups_i) begin
        done_o <= 1'b1;
      end
    end
  end

endmodule

// File: source/spmm.sv
`timescale 1ns/1ps

module spmm
  import gat_pkg::*;
(
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      group_start_i,
  input  logic [W_ROWS-1:0][W_COLS-1:0][DATA_W-1:0] w_i,
  input  node_info_t                                node_info_dout_i,
  input  logic [COL_W-1:0]                          col_idx_dout_i,
  input  logic [DATA_W-1:0]                         value_dout_i,
  output logic [NODE_INFO_ADDR_W-1:0]               node_info_addr_o,
  output logic [COL_IDX_ADDR_W-1:0]                 col_idx_addr_o,
  output logic [COL_IDX_ADDR_W-1:0]                 value_addr_o,
  output logic                                      wh_valid_o,
  output wh_row_t                                   wh_row_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_INFO,
    S_STREAM,
    S_DRAIN
  } state_t;

  state_t                      state_q;
  logic [NODE_INFO_ADDR_W-1:0] row_ptr_q;
  logic [COL_IDX_ADDR_W-1:0]   nz_ptr_q;
  logic [ROW_LEN_W-1:0]        nz_left_q;
  logic [NUM_NODES_W-1:0]      members_left_q;
  logic [NUM_NODES_W-1:0]      grp_nodes_q;
  logic                        flag_q;
  logic                        mac_valid_q;
  logic [W_COLS-1:0][WH_W-1:0] acc_q;

  // Both pointers persist across groups
  assign node_info_addr_o = row_ptr_q;
  assign col_idx_addr_o   = nz_ptr_q;
  assign value_addr_o     = nz_ptr_q;

  assign wh_row_o.wh        = acc_q;
  assign wh_row_o.flag      = flag_q;
  assign wh_row_o.num_nodes = grp_nodes_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q        <= S_IDLE;
      row_ptr_q      <= '0;
      nz_ptr_q       <= '0;
      nz_left_q      <= '0;
      members_left_q <= '0;
      mac_valid_q    <= 1'b0;
      wh_valid_o     <= 1'b0;
    end else begin
      mac_valid_q <= (state_q == S_STREAM);
      wh_valid_o  <= 1'b0;
      case (state_q)
        // Node-info address is already stable, data is back next cycle
        S_IDLE: begin
          if (group_start_i) begin
            state_q <= S_INFO;
          end
        end
        S_FETCH: begin
          state_q <= S_INFO;
        end
        S_INFO: begin
          nz_left_q <= node_info_dout_i.row_len;
          if (node_info_dout_i.flag) begin
            members_left_q <= node_info_dout_i.num_nodes;
          end
          state_q <= (node_info_dout_i.row_len == '0) ? S_DRAIN : S_STREAM;
        end
        // One nonzero issued per cycle
        S_STREAM: begin
          nz_ptr_q  <= nz_ptr_q + 1'b1;
          nz_left_q <= nz_left_q - 1'b1;
          if (nz_left_q == ROW_LEN_W'(1)) begin
            state_q <= S_DRAIN;
          end
        end
        // Last product lands here, row goes out with it
        S_DRAIN: begin
          wh_valid_o     <= 1'b1;
          row_ptr_q      <= row_ptr_q + 1'b1;
          members_left_q <= members_left_q - 1'b1;
          state_q <= (members_left_q == NUM_NODES_W'(1)) ? S_IDLE : S_FETCH;
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // MAC lanes, one per output feature
  always_ff @(posedge clk) begin
    if (state_q == S_INFO) begin
      acc_q  <= '0;
      flag_q <= node_info_dout_i.flag;
      if (node_info_dout_i.flag) begin
        grp_nodes_q <= node_info_dout_i.num_nodes;
      end
    end else if (mac_valid_q) begin
      for (int k = 0; k < W_COLS; k++) begin
        acc_q[k] <= acc_q[k] + value_dout_i * w_i[col_idx_dout_i][k];
      end
    end
  end

endmodule

// File: source/weight_loader.sv
`timescale 1ns/1ps

module weight_loader
  import gat_pkg::*;
(
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      load_done_i,
  input  logic [DATA_W-1:0]                         weight_dout_i,
  output logic [WEIGHT_ADDR_W-1:0]                  weight_addr_o,
  output logic                                      w_ready_o,
  output logic [W_ROWS-1:0][W_COLS-1:0][DATA_W-1:0] w_o
);

  logic                     load_done_q;
  logic                     busy_q;
  logic                     rd_valid_q;
  logic [WEIGHT_ADDR_W-1:0] rd_idx_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_done_q   <= 1'b0;
      busy_q        <= 1'b0;
      rd_valid_q    <= 1'b0;
      weight_addr_o <= '0;
      w_ready_o     <= 1'b0;
    end else begin
      load_done_q <= load_done_i;
      if (load_done_i && !load_done_q) begin
        busy_q <= 1'b1;
      end else if (busy_q && weight_addr_o == WEIGHT_ADDR_W'(WEIGHT_DEPTH - 1)) begin
        busy_q <= 1'b0;
      end
      if (busy_q) begin
        weight_addr_o <= weight_addr_o + 1'b1;
      end
      rd_valid_q <= busy_q;
      if (rd_valid_q && rd_idx_q == WEIGHT_ADDR_W'(WEIGHT_DEPTH - 1)) begin
        w_ready_o <= 1'b1;
      end
    end
  end

  // Read data lags the address by one cycle, row-major order
  always_ff @(posedge clk) begin
    rd_idx_q <= weight_addr_o;
    if (rd_valid_q) begin
      w_o[rd_idx_q[WEIGHT_ADDR_W-1:W_COL_W]][rd_idx_q[W_COL_W-1:0]] <= weight_dout_i;
    end
  end

endmodule
